/* build.f */
+incdir+verilog
verilog/ifu_pkg.sv
verilog/cache_dir_if.sv
verilog/cache_directory.sv
verilog/cache_mem.sv
verilog/ifu.sv
verilog/ifu_wrap.sv
verification/ifu_tb.sv

/* verification/ifu_tb.sv */
// Fetch unit testbench
`timescale 1ns/1ps
`default_nettype none
`include "ifu_config.svh"

module ifu_tb;

  localparam int CLK_PERIOD = 40;
  localparam int DIRECT_FETCHES = 7;
  localparam int HOLD_FETCHES = 6;
  localparam int RAND_FETCHES = 40;
  localparam int TOTAL_FETCHES = DIRECT_FETCHES + HOLD_FETCHES + RAND_FETCHES;
  localparam int NUM_LINES = 1 << `IFU_INDEX_WIDTH;

  logic clk;
  logic rst_n;
  ifu_pkg::addr_t next_pc_tdata;
  logic next_pc_tvalid;
  logic next_pc_tready;
  ifu_pkg::inst_t ifid_tdata_inst;
  logic inst_tvalid;
  logic inst_tready;
  ifu_pkg::addr_t araddr;
  logic [7:0] arlen;
  logic [2:0] arsize;
  logic [1:0] arburst;
  logic arvalid;
  logic arready;
  ifu_pkg::inst_t rdata;
  logic rlast;
  logic rvalid;
  logic rready;
  logic invalidate;

  integer seed = 24238;
  int burst_count = 0;
  logic stall_en = 1'b0;
  logic burst_open = 1'b0;
  ifu_pkg::inst_t exp_inst;
  ifu_pkg::addr_t exp_line;
  ifu_pkg::inst_t prev_inst;
  logic prev_hold = 1'b0;

  // Expected directory contents
  ifu_pkg::tag_t model_tag [NUM_LINES];
  logic [NUM_LINES-1:0] model_valid;

  ifu_wrap UUT (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Memory word is the address with its upper half inverted
  function automatic ifu_pkg::inst_t mem_word(ifu_pkg::addr_t addr);
    return {~addr[31:16], addr[15:0]};
  endfunction

  function automatic int random_below(int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic logic predict_miss(ifu_pkg::addr_t pc);
    ifu_pkg::index_t idx;
    idx = pc[`IFU_OFFSET_WIDTH +: `IFU_INDEX_WIDTH];
    return !(model_valid[idx] && model_tag[idx] == pc[`IFU_XLEN-1 -: `IFU_TAG_WIDTH]);
  endfunction

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1);
  endtask

  task automatic value_mismatch(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
    $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, expected);
    abort_run();
  endtask

  task automatic report_error(input string msg);
    $display("Error at %0t: %s", $time, msg);
    abort_run();
  endtask

  // Starts and returns on a falling edge
  task automatic fetch_pc(input ifu_pkg::addr_t pc, input logic expect_burst,
                          input logic hold);
    int bursts_before;
    ifu_pkg::index_t idx;
    bursts_before = burst_count;
    idx = pc[`IFU_OFFSET_WIDTH +: `IFU_INDEX_WIDTH];
    exp_inst = mem_word(pc);
    exp_line = {pc[`IFU_XLEN-1:`IFU_OFFSET_WIDTH], {`IFU_OFFSET_WIDTH{1'b0}}};
    next_pc_tdata = pc;
    next_pc_tvalid = 1'b1;
    inst_tready = !hold;
    while (!next_pc_tready) @(negedge clk);
    @(negedge clk);
    next_pc_tvalid = 1'b0;
    while (!inst_tvalid) @(negedge clk);
    if (hold) begin
      repeat (1 + random_below(5)) @(negedge clk);
      inst_tready = 1'b1;
    end
    @(negedge clk);
    inst_tready = 1'b0;
    burst_seen: assert (burst_count - bursts_before == int'(expect_burst))
      else value_mismatch("arvalid handshakes", burst_count - bursts_before, expect_burst);
    model_valid[idx] = 1'b1;
    model_tag[idx] = pc[`IFU_XLEN-1 -: `IFU_TAG_WIDTH];
  endtask

  task automatic pulse_invalidate();
    invalidate = 1'b1;
    @(negedge clk);
    invalidate = 1'b0;
    model_valid = '0;
  endtask

  // Read channel responder
  initial begin : memory_model
    ifu_pkg::addr_t base;
    arready = 1'b0;
    rvalid = 1'b0;
    rlast = 1'b0;
    rdata = '0;
    forever begin
      @(negedge clk);
      if (arvalid) begin
        repeat (random_below(4)) @(negedge clk);
        base = araddr;
        arready = 1'b1;
        @(negedge clk);
        arready = 1'b0;
        burst_open = 1'b1;
        for (int beat = 0; beat < `IFU_LINE_WORDS; beat++) begin
          if (stall_en) begin
            repeat (random_below(4)) @(negedge clk);
          end
          rvalid = 1'b1;
          rlast = (beat == `IFU_LINE_WORDS - 1);
          rdata = mem_word(base + 4 * beat);
          @(negedge clk);
          rvalid = 1'b0;
          rlast = 1'b0;
        end
        burst_open = 1'b0;
      end
    end
  end

  always @(posedge clk) begin
    prev_inst <= ifid_tdata_inst;
    prev_hold <= rst_n && inst_tvalid && !inst_tready;
    if (arvalid && arready) begin
      burst_count <= burst_count + 1;
    end
  end

  inst_data_ok: assert property (@(posedge clk) disable iff (!rst_n)
    inst_tvalid && inst_tready |-> ifid_tdata_inst == exp_inst)
    else value_mismatch("ifid_tdata_inst", $sampled(ifid_tdata_inst), $sampled(exp_inst));

  inst_valid_held: assert property (@(posedge clk) disable iff (!rst_n)
    prev_hold |-> inst_tvalid)
    else value_mismatch("inst_tvalid", $sampled(inst_tvalid), 1);

  inst_data_held: assert property (@(posedge clk) disable iff (!rst_n)
    prev_hold |-> ifid_tdata_inst == prev_inst)
    else value_mismatch("ifid_tdata_inst", $sampled(ifid_tdata_inst), $sampled(prev_inst));

  pc_blocked: assert property (@(posedge clk) disable iff (!rst_n)
    inst_tvalid |-> !next_pc_tready)
    else value_mismatch("next_pc_tready", $sampled(next_pc_tready), 0);

  // Ready for read data exactly between the address handshake and the last beat
  rready_ok: assert property (@(posedge clk) disable iff (!rst_n)
    rready == burst_open)
    else value_mismatch("rready", $sampled(rready), $sampled(burst_open));

  ar_addr_ok: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid |-> araddr == exp_line)
    else value_mismatch("araddr", $sampled(araddr), $sampled(exp_line));

  ar_len_ok: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid |-> arlen == `IFU_LINE_WORDS - 1)
    else value_mismatch("arlen", $sampled(arlen), `IFU_LINE_WORDS - 1);

  ar_size_ok: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid |-> arsize == 3'd2)
    else value_mismatch("arsize", $sampled(arsize), 2);

  ar_burst_ok: assert property (@(posedge clk) disable iff (!rst_n)
    arvalid |-> arburst == 2'b01)
    else value_mismatch("arburst", $sampled(arburst), 1);

  initial begin : watchdog
    #(200 * TOTAL_FETCHES * CLK_PERIOD);
    report_error("Watchdog expired, a fetch did not complete");
  end

  initial begin : stimulus
    ifu_pkg::addr_t pc;
    ifu_pkg::addr_t base_pc;
    rst_n = 1'b0;
    next_pc_tdata = '0;
    next_pc_tvalid = 1'b0;
    inst_tready = 1'b0;
    invalidate = 1'b0;
    exp_inst = '0;
    exp_line = '0;
    model_valid = '0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    reset_ready: assert (next_pc_tready === 1'b1)
      else value_mismatch("next_pc_tready", next_pc_tready, 1);
    reset_ar_idle: assert (arvalid === 1'b0)
      else value_mismatch("arvalid", arvalid, 0);
    reset_inst_idle: assert (inst_tvalid === 1'b0)
      else value_mismatch("inst_tvalid", inst_tvalid, 0);

    // Cold miss and then hits on the rest of the line
    base_pc = 32'h0001_2344;
    fetch_pc(base_pc, 1'b1, 1'b0);
    fetch_pc(32'h0001_2340, 1'b0, 1'b0);
    fetch_pc(32'h0001_2348, 1'b0, 1'b0);
    fetch_pc(32'h0001_234c, 1'b0, 1'b0);

    // Same index with another tag evicts the line
    fetch_pc(32'h0005_6748, 1'b1, 1'b0);
    fetch_pc(base_pc, 1'b1, 1'b0);

    pulse_invalidate();
    fetch_pc(base_pc, 1'b1, 1'b0);

    // Decoder stalls
    for (int i = 0; i < HOLD_FETCHES; i++) begin
      pc = 32'h0000_8000 + 4 * i;
      fetch_pc(pc, predict_miss(pc), 1'b1);
    end

    // Four tags share the index range so hits and evictions mix
    stall_en = 1'b1;
    for (int i = 0; i < RAND_FETCHES; i++) begin
      if (i == RAND_FETCHES / 2) begin
        pulse_invalidate();
      end
      pc = 32'h0004_0000 + 4 * random_below(256);
      fetch_pc(pc, predict_miss(pc), random_below(2) == 1);
    end
    stall_en = 1'b0;

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* verilog/cache_dir_if.sv */
// Cache directory interface
`timescale 1ns/1ps
`default_nettype none

interface cache_dir_if;

  // Lookup request and registered result
  logic lookup_en;
  ifu_pkg::index_t lookup_index;
  ifu_pkg::tag_t lookup_tag;
  logic lookup_valid;

  // Line fill
  logic fill_en;
  ifu_pkg::index_t fill_index;
  ifu_pkg::tag_t fill_tag;

  modport ctrl (
    output lookup_en,
    output lookup_index,
    input  lookup_tag,
    input  lookup_valid,
    output fill_en,
    output fill_index,
    output fill_tag
  );

  modport dir (
    input  lookup_en,
    input  lookup_index,
    output lookup_tag,
    output lookup_valid,
    input  fill_en,
    input  fill_index,
    input  fill_tag
  );

endinterface

`default_nettype wire

/* verilog/cache_directory.sv */
// Instruction cache directory
`timescale 1ns/1ps
`default_nettype none
`include "ifu_config.svh"

module cache_directory (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      invalidate,
  cache_dir_if.dir  l1i_dir_if
);

  localparam int NUM_LINES = 1 << `IFU_INDEX_WIDTH;

  ifu_pkg::tag_t tags [NUM_LINES];
  logic [NUM_LINES-1:0] valid_q;

  // Invalidate takes priority over a fill
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (invalidate) begin
      valid_q <= '0;
    end else if (l1i_dir_if.fill_en) begin
      valid_q[l1i_dir_if.fill_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (l1i_dir_if.fill_en) begin
      tags[l1i_dir_if.fill_index] <= l1i_dir_if.fill_tag;
    end
  end

  // Registered lookup, sees an invalidate at the same edge
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      l1i_dir_if.lookup_valid <= 1'b0;
    end else if (l1i_dir_if.lookup_en) begin
      l1i_dir_if.lookup_valid <= valid_q[l1i_dir_if.lookup_index] && !invalidate;
    end
  end

  always_ff @(posedge clk) begin
    if (l1i_dir_if.lookup_en) begin
      l1i_dir_if.lookup_tag <= tags[l1i_dir_if.lookup_index];
    end
  end

  // Controller never looks up while it fills
  fill_lookup_excl: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(l1i_dir_if.fill_en && l1i_dir_if.lookup_en)
  );

endmodule

`default_nettype wire

/* verilog/cache_mem.sv */
// Instruction cache line store
`timescale 1ns/1ps
`default_nettype none
`include "ifu_config.svh"

module cache_mem (
  input  logic                clk,
  input  logic                rd_en,
  input  ifu_pkg::index_t     rd_index,
  input  ifu_pkg::word_sel_t  rd_word,
  output ifu_pkg::inst_t      rd_data,
  input  logic                wr_en,
  input  ifu_pkg::index_t     wr_index,
  input  ifu_pkg::line_t      wr_line
);

  localparam int NUM_LINES = 1 << `IFU_INDEX_WIDTH;

  ifu_pkg::line_t lines [NUM_LINES];

  // Whole line written at once
  always_ff @(posedge clk) begin
    if (wr_en) begin
      lines[wr_index] <= wr_line;
    end
  end

  // Word read, one cycle latency
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= lines[rd_index][rd_word*`IFU_XLEN +: `IFU_XLEN];
    end
  end

endmodule

`default_nettype wire

/* verilog/ifu.sv */
// Instruction fetch controller
`timescale 1ns/1ps
`default_nettype none
`include "ifu_config.svh"

module ifu (
  input  logic                clk,
  input  logic                rst_n,

  // Program counter stream
  input  ifu_pkg::addr_t      next_pc_tdata,
  input  logic                next_pc_tvalid,
  output logic                next_pc_tready,

  // Instruction stream
  output ifu_pkg::inst_t      ifid_tdata_inst,
  output logic                inst_tvalid,
  input  logic                inst_tready,

  // Read address channel
  output ifu_pkg::addr_t      araddr,
  output logic [7:0]          arlen,
  output logic [2:0]          arsize,
  output logic [1:0]          arburst,
  output logic                arvalid,
  input  logic                arready,

  // Read data channel
  input  ifu_pkg::inst_t      rdata,
  input  logic                rlast,
  input  logic                rvalid,
  output logic                rready,

  cache_dir_if.ctrl           l1i_dir_if,

  // Line store
  output logic                mem_rd_en,
  output ifu_pkg::index_t     mem_rd_index,
  output ifu_pkg::word_sel_t  mem_rd_word,
  input  ifu_pkg::inst_t      mem_rd_data,
  output logic                mem_wr_en,
  output ifu_pkg::index_t     mem_wr_index,
  output ifu_pkg::line_t      mem_wr_line
);

  ifu_pkg::fetch_state_t state_q;
  ifu_pkg::addr_t pc_q;
  ifu_pkg::addr_t lookup_pc;
  ifu_pkg::inst_t inst_q;
  ifu_pkg::line_t line_q;
  logic replay_q;
  logic pc_fire;
  logic lookup_go;
  logic write_go;
  logic compare;
  logic hit;

  function automatic ifu_pkg::tag_t pc_tag(ifu_pkg::addr_t pc);
    return pc[`IFU_XLEN-1 -: `IFU_TAG_WIDTH];
  endfunction

  function automatic ifu_pkg::index_t pc_index(ifu_pkg::addr_t pc);
    return pc[`IFU_OFFSET_WIDTH +: `IFU_INDEX_WIDTH];
  endfunction

  function automatic ifu_pkg::word_sel_t pc_word(ifu_pkg::addr_t pc);
    return pc[`IFU_OFFSET_WIDTH-1:2];
  endfunction

  assign next_pc_tready = (state_q == ifu_pkg::IDLE);
  assign pc_fire = next_pc_tvalid && next_pc_tready;

  // First lookup takes the incoming PC and the replay takes the held one
  assign lookup_pc = (state_q == ifu_pkg::IDLE) ? next_pc_tdata : pc_q;
  assign lookup_go = pc_fire || (state_q == ifu_pkg::LOOKUP && replay_q);
  assign compare = (state_q == ifu_pkg::LOOKUP) && !replay_q;

  assign l1i_dir_if.lookup_en = lookup_go;
  assign l1i_dir_if.lookup_index = pc_index(lookup_pc);
  assign mem_rd_en = lookup_go;
  assign mem_rd_index = pc_index(lookup_pc);
  assign mem_rd_word = pc_word(lookup_pc);

  assign hit = l1i_dir_if.lookup_valid && (l1i_dir_if.lookup_tag == pc_tag(pc_q));

  // Line and tag land in the same cycle
  assign write_go = (state_q == ifu_pkg::WRITE);
  assign mem_wr_en = write_go;
  assign mem_wr_index = pc_index(pc_q);
  assign mem_wr_line = line_q;
  assign l1i_dir_if.fill_en = write_go;
  assign l1i_dir_if.fill_index = pc_index(pc_q);
  assign l1i_dir_if.fill_tag = pc_tag(pc_q);

  // Line burst of 4-byte INCR beats
  assign arvalid = (state_q == ifu_pkg::REQ);
  assign araddr = {pc_tag(pc_q), pc_index(pc_q), {`IFU_OFFSET_WIDTH{1'b0}}};
  assign arlen = 8'(`IFU_LINE_WORDS - 1);
  assign arsize = 3'd2;
  assign arburst = 2'b01;
  assign rready = (state_q == ifu_pkg::FILL);

  assign inst_tvalid = (state_q == ifu_pkg::SEND);
  assign ifid_tdata_inst = inst_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ifu_pkg::IDLE;
      replay_q <= 1'b0;
    end else begin
      case (state_q)
        ifu_pkg::IDLE: begin
          if (pc_fire) begin
            state_q <= ifu_pkg::LOOKUP;
          end
        end
        ifu_pkg::LOOKUP: begin
          if (replay_q) begin
            replay_q <= 1'b0;
          end else if (hit) begin
            state_q <= ifu_pkg::SEND;
          end else begin
            state_q <= ifu_pkg::REQ;
          end
        end
        ifu_pkg::REQ: begin
          if (arready) begin
            state_q <= ifu_pkg::FILL;
          end
        end
        ifu_pkg::FILL: begin
          if (rvalid && rlast) begin
            state_q <= ifu_pkg::WRITE;
          end
        end
        ifu_pkg::WRITE: begin
          state_q <= ifu_pkg::LOOKUP;
          replay_q <= 1'b1;
        end
        ifu_pkg::SEND: begin
          if (inst_tready) begin
            state_q <= ifu_pkg::IDLE;
          end
        end
        default: state_q <= ifu_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (pc_fire) begin
      pc_q <= next_pc_tdata;
    end
    if (compare) begin
      inst_q <= mem_rd_data;
    end
    // Word 0 arrives first and ends at the bottom
    if (rvalid && rready) begin
      line_q <= {rdata, line_q[$bits(ifu_pkg::line_t)-1:`IFU_XLEN]};
    end
  end

  ar_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    arvalid && !arready |=> arvalid && $stable(araddr)
  );

  inst_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    inst_tvalid && !inst_tready |=> inst_tvalid && $stable(ifid_tdata_inst)
  );

  // Read data only comes for the burst in flight
  r_only_in_fill: assert property (
    @(posedge clk) disable iff (!rst_n)
    rvalid |-> state_q == ifu_pkg::FILL
  );

endmodule

`default_nettype wire

/* verilog/ifu_config.svh */
// Fetch unit configuration
`ifndef IFU_CONFIG_SVH
`define IFU_CONFIG_SVH

// Instruction and PC width
`define IFU_XLEN 32

// Words per cache line
`define IFU_LINE_WORDS 4

// Line index bits, 16 lines
`define IFU_INDEX_WIDTH 4

// Byte offset within a line
`define IFU_OFFSET_WIDTH 4

// PC bits above index and offset
`define IFU_TAG_WIDTH 24

`endif

/* verilog/ifu_pkg.sv */
// Fetch unit types
`default_nettype none
`include "ifu_config.svh"

package ifu_pkg;

  typedef logic [`IFU_XLEN-1:0] addr_t;
  typedef logic [`IFU_XLEN-1:0] inst_t;
  typedef logic [`IFU_TAG_WIDTH-1:0] tag_t;
  typedef logic [`IFU_INDEX_WIDTH-1:0] index_t;
  typedef logic [$clog2(`IFU_LINE_WORDS)-1:0] word_sel_t;
  typedef logic [`IFU_LINE_WORDS*`IFU_XLEN-1:0] line_t;

  // Fetch controller states
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    REQ,
    FILL,
    WRITE,
    SEND
  } fetch_state_t;

endpackage

`default_nettype wire

/* verilog/ifu_wrap.sv */
// Instruction fetch unit top
`timescale 1ns/1ps
`default_nettype none

module ifu_wrap (
  input  logic            clk,
  input  logic            rst_n,

  // From the PC generator
  input  ifu_pkg::addr_t  next_pc_tdata,
  input  logic            next_pc_tvalid,
  output logic            next_pc_tready,

  // To the decoder
  output ifu_pkg::inst_t  ifid_tdata_inst,
  output logic            inst_tvalid,
  input  logic            inst_tready,

  // Read address channel
  output ifu_pkg::addr_t  araddr,
  output logic [7:0]      arlen,
  output logic [2:0]      arsize,
  output logic [1:0]      arburst,
  output logic            arvalid,
  input  logic            arready,

  // Read data channel
  input  ifu_pkg::inst_t  rdata,
  input  logic            rlast,
  input  logic            rvalid,
  output logic            rready,

  input  logic            invalidate
);

  cache_dir_if l1i_dir_if_0 ();

  logic mem_rd_en;
  ifu_pkg::index_t mem_rd_index;
  ifu_pkg::word_sel_t mem_rd_word;
  ifu_pkg::inst_t mem_rd_data;
  logic mem_wr_en;
  ifu_pkg::index_t mem_wr_index;
  ifu_pkg::line_t mem_wr_line;

  ifu ifu_inst (
    .clk(clk),
    .rst_n(rst_n),
    .next_pc_tdata(next_pc_tdata),
    .next_pc_tvalid(next_pc_tvalid),
    .next_pc_tready(next_pc_tready),
    .ifid_tdata_inst(ifid_tdata_inst),
    .inst_tvalid(inst_tvalid),
    .inst_tready(inst_tready),
    .araddr(araddr),
    .arlen(arlen),
    .arsize(arsize),
    .arburst(arburst),
    .arvalid(arvalid),
    .arready(arready),
    .rdata(rdata),
    .rlast(rlast),
    .rvalid(rvalid),
    .rready(rready),
    .l1i_dir_if(l1i_dir_if_0),
    .mem_rd_en(mem_rd_en),
    .mem_rd_index(mem_rd_index),
    .mem_rd_word(mem_rd_word),
    .mem_rd_data(mem_rd_data),
    .mem_wr_en(mem_wr_en),
    .mem_wr_index(mem_wr_index),
    .mem_wr_line(mem_wr_line)
  );

  cache_directory l1i_dir_inst (
    .clk(clk),
    .rst_n(rst_n),
    .invalidate(invalidate),
    .l1i_dir_if(l1i_dir_if_0)
  );

  cache_mem l1i_mem_inst (
    .clk(clk),
    .rd_en(mem_rd_en),
    .rd_index(mem_rd_index),
    .rd_word(mem_rd_word),
    .rd_data(mem_rd_data),
    .wr_en(mem_wr_en),
    .wr_index(mem_wr_index),
    .wr_line(mem_wr_line)
  );

endmodule

`default_nettype wire
